// File: filelist.f
+incdir+.
gb_io_pkg.sv
io_decode.sv
irq_regs.sv
irq_dispatch_fsm.sv
io_timer.sv
joypad_port.sv
gb_io_top.sv
tb_gb_io.sv

// File: tb_gb_io.sv
// Game Boy I/O core testbench
// table of bus accesses, source pulses and joypad levels applied in a loop,
// each entry checked against its expected read value, irq_n_o or p54
`timescale 1ns/1ps
`include "gb_io_defs.svh"

module tb_gb_io
	import gb_io_pkg::*;
;

	localparam int MAX_TESTS = 64;
	localparam logic [1:0] C_RD  = 2'd0;  // compare cpu_rdata_o
	localparam logic [1:0] C_IRQ = 2'd1;  // compare irq_n_o
	localparam logic [1:0] C_P54 = 2'd2;  // compare joy_p54_o

	localparam io_addr_t A_P1   = `IO_ADDR_P1;
	localparam io_addr_t A_DIV  = `IO_ADDR_DIV;
	localparam io_addr_t A_TIMA = `IO_ADDR_TIMA;
	localparam io_addr_t A_TMA  = `IO_ADDR_TMA;
	localparam io_addr_t A_TAC  = `IO_ADDR_TAC;
	localparam io_addr_t A_IF   = `IO_ADDR_IF;
	localparam io_addr_t A_IE   = `IO_ADDR_IE;

	logic       clk_sys = 1'b0;
	logic       reset_ss;
	cpu_bus_t   cpu_bus;
	io_data_t   cpu_rdata;
	logic       irq_ack, irq_n;
	logic       vblank_irq, lcd_irq, serial_irq;
	joy_lines_t joy_din;
	logic [1:0] joy_p54;

	// stimulus table --------------------
	string      t_name  [MAX_TESTS];
	io_addr_t   t_addr  [MAX_TESTS];
	io_data_t   t_wdata [MAX_TESTS];
	logic       t_wr    [MAX_TESTS];
	irq_bits_t  t_src   [MAX_TESTS];  // irq order, only 0, 1, 3 driven
	joy_lines_t t_joy   [MAX_TESTS];
	logic       t_ack   [MAX_TESTS];
	int         t_wait  [MAX_TESTS];
	io_data_t   t_exp   [MAX_TESTS];
	logic [1:0] t_chk   [MAX_TESTS];
	int         n_tests = 0;

	integer     seed = 18;
	int         cycle_limit = 0;
	int         cycles = 0;

	gb_io_top gb_io_top_i (
		.clk_sys      (clk_sys),
		.reset_ss     (reset_ss),
		.cpu_bus_i    (cpu_bus),
		.cpu_rdata_o  (cpu_rdata),
		.irq_ack_i    (irq_ack),
		.irq_n_o      (irq_n),
		.vblank_irq_i (vblank_irq),
		.lcd_irq_i    (lcd_irq),
		.serial_irq_i (serial_irq),
		.joy_din_i    (joy_din),
		.joy_p54_o    (joy_p54)
	);

	always #50 clk_sys = ~clk_sys;  // 100 ns period

	task add_test(input string name, input io_addr_t addr, input io_data_t wdata,
	              input logic wr, input irq_bits_t src, input joy_lines_t joy,
	              input logic ack, input int wait_cyc, input io_data_t exp,
	              input logic [1:0] chk);
		t_name[n_tests]  = name;
		t_addr[n_tests]  = addr;
		t_wdata[n_tests] = wdata;
		t_wr[n_tests]    = wr;
		t_src[n_tests]   = src;
		t_joy[n_tests]   = joy;
		t_ack[n_tests]   = ack;
		t_wait[n_tests]  = wait_cyc;
		t_exp[n_tests]   = exp;
		t_chk[n_tests]   = chk;
		n_tests++;
	endtask

	// drive 10 ns after the edge, drop strobes after the first edge, sample mid-cycle
	task run_entry(input int idx);
		io_data_t actual;
		@(posedge clk_sys);
		#10;
		cpu_bus.addr  = t_addr[idx];
		cpu_bus.wdata = t_wdata[idx];
		cpu_bus.wr    = t_wr[idx];
		vblank_irq    = t_src[idx][0];
		lcd_irq       = t_src[idx][1];
		serial_irq    = t_src[idx][3];
		joy_din       = t_joy[idx];
		irq_ack       = t_ack[idx];   // held until the next entry
		for (int k = 0; k < t_wait[idx]; k++) begin
			@(posedge clk_sys);
			#10;
			cpu_bus.wr = 1'b0;          // one-cycle write
			vblank_irq = 1'b0;
			lcd_irq    = 1'b0;
			serial_irq = 1'b0;
		end
		#40;
		case (t_chk[idx])
			C_IRQ:   actual = {7'b0, irq_n};
			C_P54:   actual = {6'b0, joy_p54};
			default: actual = cpu_rdata;
		endcase
		assert (actual === t_exp[idx]) else begin
			$display("Mismatch in %s: expected %h, actual %h", t_name[idx], t_exp[idx], actual);
			$display("Regression failed");
			$fatal(1, "stopped at first error");
		end
	endtask

	// timeout --------------------
	initial begin
		wait (cycle_limit > 0);
		while (cycles < cycle_limit) begin
			@(posedge clk_sys);
			cycles++;
		end
		$display("Timeout: run exceeded %0d clock cycles", cycle_limit);
		$display("Regression failed");
		$fatal(1, "timeout");
	end

	initial begin
		logic [31:0] rnd;
		joy_lines_t  jr;
		int          wait_sum;
		reset_ss   = 1'b1;
		cpu_bus    = '0;
		irq_ack    = 1'b0;
		vblank_irq = 1'b0;
		lcd_irq    = 1'b0;
		serial_irq = 1'b0;
		joy_din    = '0;
		rnd        = $random(seed);
		jr         = rnd[3:0];  // held until the joypad section, rises only

		// reset values
		add_test("if_reset",    A_IF,     8'h00, 0, 5'h00, 4'h0, 0, 0, 8'hE0, C_RD);
		add_test("ie_reset",    A_IE,     8'h00, 0, 5'h00, 4'h0, 0, 0, 8'h00, C_RD);
		add_test("tac_reset",   A_TAC,    8'h00, 0, 5'h00, 4'h0, 0, 0, 8'hF8, C_RD);
		add_test("tima_reset",  A_TIMA,   8'h00, 0, 5'h00, 4'h0, 0, 0, 8'h00, C_RD);
		add_test("p1_reset",    A_P1,     8'h00, 0, 5'h00, 4'h0, 0, 0, 8'hC0, C_RD);
		add_test("irq_n_reset", A_IF,     8'h00, 0, 5'h00, 4'h0, 0, 0, 8'h01, C_IRQ);
		add_test("unmapped",    16'hC000, 8'h00, 0, 5'h00, 4'h0, 0, 0, 8'hFF, C_RD);
		add_test("unmapped_io", 16'hFF01, 8'h00, 0, 5'h00, 4'h0, 0, 0, 8'hFF, C_RD);
		// register writes and read formats
		add_test("ie_write",  A_IE,  8'hA0, 1, 5'h00, 4'h0, 0, 1, 8'hA0, C_RD);
		add_test("tma_write", A_TMA, 8'h5A, 1, 5'h00, 4'h0, 0, 1, 8'h5A, C_RD);
		add_test("tac_write", A_TAC, 8'h03, 1, 5'h00, 4'h0, 0, 1, 8'hFB, C_RD); // disabled
		add_test("p1_write",  A_P1,  8'h20, 1, 5'h00, jr, 0, 3, {4'hE, jr}, C_RD);
		add_test("p54_out",   A_P1,  8'h00, 0, 5'h00, jr, 0, 0, 8'h02, C_P54);
		add_test("p1_write_b", A_P1, 8'h1F, 1, 5'h00, jr, 0, 1, {4'hD, jr}, C_RD);
		add_test("p54_out_b",  A_P1, 8'h00, 0, 5'h00, jr, 0, 0, 8'h01, C_P54);
		// timer, TIMA ticks 17 + 16m edges after the DIV write
		add_test("tma_load",     A_TMA,  8'hF0, 1, 5'h00, jr, 0, 1, 8'hF0, C_RD);
		add_test("tac_enable",   A_TAC,  8'h05, 1, 5'h00, jr, 0, 1, 8'hFD, C_RD);
		add_test("div_clear",    A_DIV,  8'h77, 1, 5'h00, jr, 0, 1, 8'h00, C_RD);
		add_test("tima_clear",   A_TIMA, 8'h00, 1, 5'h00, jr, 0, 1, 8'h00, C_RD);
		add_test("tima_n1",      A_TIMA, 8'h00, 0, 5'h00, jr, 0, 21, 8'h01, C_RD); // +24
		add_test("tima_n2",      A_TIMA, 8'h00, 0, 5'h00, jr, 0, 15, 8'h02, C_RD); // +40
		add_test("tima_n3",      A_TIMA, 8'h00, 0, 5'h00, jr, 0, 15, 8'h03, C_RD); // +56
		add_test("tima_preload", A_TIMA, 8'hFE, 1, 5'h00, jr, 0, 1, 8'hFE, C_RD);
		add_test("tima_reload",  A_TIMA, 8'h00, 0, 5'h00, jr, 0, 30, 8'hF0, C_RD); // +89
		add_test("if_timer",     A_IF,   8'h00, 0, 5'h00, jr, 0, 0, 8'hE4, C_RD);
		add_test("irq_n_masked", A_IF,   8'h00, 0, 5'h00, jr, 0, 0, 8'h01, C_IRQ);
		add_test("ie_timer",     A_IE,   8'h04, 1, 5'h00, jr, 0, 1, 8'h04, C_RD);
		add_test("irq_n_timer",  A_IF,   8'h00, 0, 5'h00, jr, 0, 0, 8'h00, C_IRQ);
		add_test("tac_stop",     A_TAC,  8'h00, 1, 5'h00, jr, 0, 1, 8'hF8, C_RD);
		add_test("if_clear",     A_IF,   8'h00, 1, 5'h00, jr, 0, 1, 8'hE0, C_RD);
		// vblank and serial, then two ack cycles
		add_test("src_pulse",     A_IF, 8'h00, 0, 5'h09, jr, 0, 2, 8'hE9, C_RD);
		add_test("ie_all",        A_IE, 8'h1F, 1, 5'h00, jr, 0, 1, 8'h1F, C_RD);
		add_test("irq_n_pending", A_IF, 8'h00, 0, 5'h00, jr, 0, 0, 8'h00, C_IRQ);
		add_test("ack_vblank",    A_IF, 8'h00, 0, 5'h00, jr, 1, 0, 8'h40, C_RD);
		add_test("if_after_ack",  A_IF, 8'h00, 0, 5'h00, jr, 0, 1, 8'hE8, C_RD);
		add_test("ack_serial",    A_IF, 8'h00, 0, 5'h00, jr, 1, 0, 8'h58, C_RD);
		add_test("if_after_ack2", A_IF, 8'h00, 0, 5'h00, jr, 0, 1, 8'hE0, C_RD);
		add_test("irq_n_idle",    A_IF, 8'h00, 0, 5'h00, jr, 0, 0, 8'h01, C_IRQ);
		// joypad falling edge
		add_test("joy_high",      A_P1, 8'h00, 0, 5'h00, 4'hF, 0, 3, 8'hDF, C_RD);
		add_test("joy_fall",      A_IF, 8'h00, 0, 5'h00, 4'h0, 0, 4, 8'hF0, C_RD);
		add_test("irq_n_joy",     A_IF, 8'h00, 0, 5'h00, 4'h0, 0, 0, 8'h00, C_IRQ);
		add_test("if_write_zero", A_IF, 8'h00, 1, 5'h00, 4'h0, 0, 1, 8'hE0, C_RD);
		add_test("irq_n_clear",   A_IF, 8'h00, 0, 5'h00, 4'h0, 0, 0, 8'h01, C_IRQ);

		wait_sum = 0;
		for (int i = 0; i < n_tests; i++) begin
			wait_sum += t_wait[i];
		end
		cycle_limit = 2 * wait_sum + 100;

		repeat (2) @(posedge clk_sys);
		#10;
		reset_ss = 1'b0;

		for (int i = 0; i < n_tests; i++) begin
			run_entry(i);
		end

		$display("Regression passed");
		$finish;
	end

endmodule

// File: gb_io_top.sv
// Game Boy I/O core top level
// register decode, interrupt controller, timer and joypad port
`timescale 1ns/1ps

module gb_io_top
	import gb_io_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset_ss,
	input  cpu_bus_t   cpu_bus_i,
	output io_data_t   cpu_rdata_o,
	input  logic       irq_ack_i,
	output logic       irq_n_o,
	input  logic       vblank_irq_i,
	input  logic       lcd_irq_i,
	input  logic       serial_irq_i,
	input  joy_lines_t joy_din_i,
	output logic [1:0] joy_p54_o
);

	io_sel_t   io_sel;
	io_data_t  timer_rdata, joy_rdata, if_rdata, ie_rdata;
	io_data_t  irq_vector;
	logic      timer_irq, joy_irq;
	irq_bits_t irq_active, irq_clear;

	// decode --------------------
	io_decode io_decode_i (
		.cpu_addr_i    (cpu_bus_i.addr),
		.io_sel_o      (io_sel),
		.timer_rdata_i (timer_rdata),
		.joy_rdata_i   (joy_rdata),
		.if_rdata_i    (if_rdata),
		.ie_rdata_i    (ie_rdata),
		.irq_ack_i     (irq_ack_i),
		.irq_vector_i  (irq_vector),
		.cpu_rdata_o   (cpu_rdata_o)
	);

	// interrupts --------------------
	irq_regs irq_regs_i (
		.clk_sys      (clk_sys),
		.reset_ss     (reset_ss),
		.sel_if_i     (io_sel.sel_if),
		.sel_ie_i     (io_sel.sel_ie),
		.wr_i         (cpu_bus_i.wr),
		.wdata_i      (cpu_bus_i.wdata),
		.src_i        ({joy_irq, serial_irq_i, timer_irq, lcd_irq_i, vblank_irq_i}),
		.irq_clear_i  (irq_clear),
		.irq_active_o (irq_active),
		.if_rdata_o   (if_rdata),
		.ie_rdata_o   (ie_rdata)
	);

	irq_dispatch_fsm irq_dispatch_fsm_i (
		.clk_sys      (clk_sys),
		.reset_ss     (reset_ss),
		.irq_ack_i    (irq_ack_i),
		.irq_active_i (irq_active),
		.irq_vector_o (irq_vector),
		.irq_clear_o  (irq_clear),
		.irq_n_o      (irq_n_o)
	);

	// timer and joypad --------------------
	io_timer io_timer_i (
		.clk_sys     (clk_sys),
		.reset_ss    (reset_ss),
		.sel_timer_i (io_sel.sel_timer),
		.wr_i        (cpu_bus_i.wr),
		.addr_i      (cpu_bus_i.addr[1:0]),
		.wdata_i     (cpu_bus_i.wdata),
		.rdata_o     (timer_rdata),
		.timer_irq_o (timer_irq)
	);

	joypad_port joypad_port_i (
		.clk_sys   (clk_sys),
		.reset_ss  (reset_ss),
		.sel_joy_i (io_sel.sel_joy),
		.wr_i      (cpu_bus_i.wr),
		.wdata_i   (cpu_bus_i.wdata),
		.joy_din_i (joy_din_i),
		.rdata_o   (joy_rdata),
		.joy_p54_o (joy_p54_o),
		.joy_irq_o (joy_irq)
	);

endmodule

// File: joypad_port.sv
// Joypad port P1
// line-select bits p54 and synchronised P10..P13 with falling-edge irq
`timescale 1ns/1ps
`include "gb_io_defs.svh"

module joypad_port
	import gb_io_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset_ss,
	input  logic       sel_joy_i,
	input  logic       wr_i,
	input  io_data_t   wdata_i,
	input  joy_lines_t joy_din_i,
	output io_data_t   rdata_o,
	output logic [1:0] joy_p54_o,
	output logic       joy_irq_o
);

	logic [1:0] p54;
	joy_lines_t joy_q1;   // newer sample
	joy_lines_t joy_q2;   // older sample

	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			p54    <= `P54_RESET_VAL;
			joy_q1 <= '0;
			joy_q2 <= '0;
		end else begin
			joy_q1 <= joy_din_i;
			joy_q2 <= joy_q1;
			if (sel_joy_i && wr_i) begin
				p54 <= wdata_i[5:4];  // only the select bits are writable
			end
		end
	end

	// any line high before, low now
	assign joy_irq_o = |(joy_q2 & ~joy_q1);

	assign rdata_o   = {2'b11, p54, joy_q1};
	assign joy_p54_o = p54;

endmodule

// File: io_timer.sv
// Timer block
// free-running system counter with DIV on top, TIMA clocked from a
// TAC-selected counter tap, TMA reload on overflow and timer interrupt
`timescale 1ns/1ps
`include "gb_io_defs.svh"

module io_timer
	import gb_io_pkg::*;
(
	input  logic     clk_sys,
	input  logic     reset_ss,
	input  logic     sel_timer_i,
	input  logic     wr_i,
	input  logic [1:0] addr_i,      // FF04..FF07 offset
	input  io_data_t wdata_i,
	output io_data_t rdata_o,
	output logic     timer_irq_o
);

	localparam io_addr_t A_DIV  = `IO_ADDR_DIV;
	localparam io_addr_t A_TIMA = `IO_ADDR_TIMA;
	localparam io_addr_t A_TMA  = `IO_ADDR_TMA;
	localparam io_addr_t A_TAC  = `IO_ADDR_TAC;

	logic [15:0] sys_cnt;
	io_data_t    tima;
	io_data_t    tma;
	logic [2:0]  tac;          // enable, mode[1:0]
	logic        tap_bit;
	logic        tap_en;
	logic        tap_q;
	logic        tima_tick;
	logic        timer_irq_q;
	logic        wr_div, wr_tima, wr_tma, wr_tac;

	// write decode
	assign wr_div  = sel_timer_i & wr_i & (addr_i == A_DIV[1:0]);
	assign wr_tima = sel_timer_i & wr_i & (addr_i == A_TIMA[1:0]);
	assign wr_tma  = sel_timer_i & wr_i & (addr_i == A_TMA[1:0]);
	assign wr_tac  = sel_timer_i & wr_i & (addr_i == A_TAC[1:0]);

	// tap select --------------------
	always_comb begin
		case (tac[1:0])
			2'd0:    tap_bit = sys_cnt[`TIMER_TAP_0];
			2'd1:    tap_bit = sys_cnt[`TIMER_TAP_1];
			2'd2:    tap_bit = sys_cnt[`TIMER_TAP_2];
			default: tap_bit = sys_cnt[`TIMER_TAP_3];
		endcase
	end

	assign tap_en    = tac[2] & tap_bit;
	assign tima_tick = tap_q & ~tap_en;  // falling tap

	// counters --------------------
	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			sys_cnt     <= '0;
			tap_q       <= 1'b0;
			tima        <= `TIMA_RESET_VAL;
			tma         <= `TMA_RESET_VAL;
			tac         <= `TAC_RESET_VAL;
			timer_irq_q <= 1'b0;
		end else begin
			sys_cnt     <= wr_div ? 16'h0000 : sys_cnt + 16'd1;
			tap_q       <= wr_div ? 1'b0 : tap_en;  // DIV write restarts the period
			timer_irq_q <= 1'b0;
			if (wr_tima) begin
				tima <= wdata_i;
			end else if (tima_tick) begin
				if (tima == 8'hFF) begin
					tima        <= tma;     // reload same edge
					timer_irq_q <= 1'b1;    // irq next cycle
				end else begin
					tima <= tima + 8'd1;
				end
			end
			if (wr_tma) tma <= wdata_i;
			if (wr_tac) tac <= wdata_i[2:0];
		end
	end

	// readback --------------------
	always_comb begin
		case (addr_i)
			A_DIV[1:0]:  rdata_o = sys_cnt[15:8];
			A_TIMA[1:0]: rdata_o = tima;
			A_TMA[1:0]:  rdata_o = tma;
			A_TAC[1:0]:  rdata_o = {5'b11111, tac};
			default:     rdata_o = `OPEN_BUS_DATA;
		endcase
	end

	assign timer_irq_o = timer_irq_q;

endmodule

// File: irq_dispatch_fsm.sv
// Interrupt dispatch
// tracks the CPU acknowledge cycle, drives the priority vector and
// requests the clear of the serviced flag once the ack ends
`timescale 1ns/1ps
`include "gb_io_defs.svh"

module irq_dispatch_fsm
	import gb_io_pkg::*;
(
	input  logic      clk_sys,
	input  logic      reset_ss,
	input  logic      irq_ack_i,
	input  irq_bits_t irq_active_i,
	output io_data_t  irq_vector_o,
	output irq_bits_t irq_clear_o,
	output logic      irq_n_o
);

	irq_state_t state;
	irq_state_t state_next;
	irq_bits_t  lowest;    // one-hot, highest priority active
	logic [2:0] irq_idx;
	logic       found;

	// priority pick --------------------
	always_comb begin
		lowest  = '0;
		irq_idx = '0;
		found   = 1'b0;
		for (int i = 0; i < $bits(irq_bits_t); i++) begin
			if (irq_active_i[i] && !found) begin
				lowest[i] = 1'b1;
				irq_idx   = i[2:0];
				found     = 1'b1;
			end
		end
	end

	// 40, 48, 50, 58, 60
	assign irq_vector_o = found ? io_data_t'(`IRQ_VEC_BASE + `IRQ_VEC_STEP * irq_idx)
	                            : 8'h00;

	// ack tracking --------------------
	always_comb begin
		state_next = state;
		case (state)
			IRQ_IDLE: if (irq_ack_i) state_next = IRQ_ACK;
			IRQ_ACK:  if (!irq_ack_i) state_next = IRQ_IDLE;  // ack released
			default:  state_next = IRQ_IDLE;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			state <= IRQ_IDLE;
		end else begin
			state <= state_next;
		end
	end

	// single cycle, on the falling ack
	assign irq_clear_o = (state == IRQ_ACK && !irq_ack_i) ? lowest : '0;

	assign irq_n_o = ~|irq_active_i;  // low while anything enabled is pending

endmodule

// File: irq_regs.sv
// Interrupt flag and enable registers
// rising-edge capture of the five sources, ack clear and CPU access
`timescale 1ns/1ps
`include "gb_io_defs.svh"

module irq_regs
	import gb_io_pkg::*;
(
	input  logic      clk_sys,
	input  logic      reset_ss,

	input  logic      sel_if_i,
	input  logic      sel_ie_i,
	input  logic      wr_i,
	input  io_data_t  wdata_i,

	input  irq_bits_t src_i,        // raw source levels
	input  irq_bits_t irq_clear_i,  // one-hot from dispatch

	output irq_bits_t irq_active_o,
	output io_data_t  if_rdata_o,
	output io_data_t  ie_rdata_o
);

	irq_bits_t if_r;     // pending flags
	io_data_t  ie_r;     // all 8 bits stored, low 5 used
	irq_bits_t src_q;    // previous source levels
	irq_bits_t src_rise;
	irq_bits_t if_next;

	// low to high since last cycle
	assign src_rise = src_i & ~src_q;

	// set first, then the ack clear on top
	always_comb begin
		if_next = (if_r | src_rise) & ~irq_clear_i;
		if (sel_if_i && wr_i) begin
			if_next = wdata_i[4:0];  // CPU write wins
		end
	end

	// registers --------------------
	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			if_r  <= `IF_RESET_VAL;
			ie_r  <= `IE_RESET_VAL;
			src_q <= '0;              // level high out of reset counts as edge
		end else begin
			src_q <= src_i;
			if_r  <= if_next;
			if (sel_ie_i && wr_i) begin
				ie_r <= wdata_i;
			end
		end
	end

	// outputs --------------------
	assign irq_active_o = if_r & ie_r[4:0];
	assign if_rdata_o   = {3'b111, if_r};  // unused bits read high
	assign ie_rdata_o   = ie_r;

endmodule

// File: io_decode.sv
// I/O address decode and CPU read multiplexer
// forms register selects and picks the byte returned to the CPU
`timescale 1ns/1ps
`include "gb_io_defs.svh"

module io_decode
	import gb_io_pkg::*;
(
	input  io_addr_t cpu_addr_i,
	output io_sel_t  io_sel_o,

	input  io_data_t timer_rdata_i,
	input  io_data_t joy_rdata_i,
	input  io_data_t if_rdata_i,
	input  io_data_t ie_rdata_i,

	input  logic     irq_ack_i,
	input  io_data_t irq_vector_i,

	output io_data_t cpu_rdata_o
);

	// timer block covers FF04..FF07, only the top 14 bits matter
	localparam io_addr_t TIMER_BASE = `IO_ADDR_DIV;

	// selects --------------------
	always_comb begin
		io_sel_o.sel_joy   = (cpu_addr_i == `IO_ADDR_P1);
		io_sel_o.sel_timer = (cpu_addr_i[15:2] == TIMER_BASE[15:2]);
		io_sel_o.sel_if    = (cpu_addr_i == `IO_ADDR_IF);
		io_sel_o.sel_ie    = (cpu_addr_i == `IO_ADDR_IE);
	end

	// read mux --------------------
	// vector first so the ack cycle never sees register data
	always_comb begin
		if (irq_ack_i) begin
			cpu_rdata_o = irq_vector_i;
		end else if (io_sel_o.sel_if) begin
			cpu_rdata_o = if_rdata_i;     // upper bits already forced high
		end else if (io_sel_o.sel_joy) begin
			cpu_rdata_o = joy_rdata_i;
		end else if (io_sel_o.sel_timer) begin
			cpu_rdata_o = timer_rdata_i;
		end else if (io_sel_o.sel_ie) begin
			cpu_rdata_o = ie_rdata_i;
		end else begin
			cpu_rdata_o = `OPEN_BUS_DATA;  // unmapped
		end
	end

endmodule

// File: gb_io_pkg.sv
// Game Boy I/O core types
// bus widths, CPU bus bundle, register selects and dispatch states
package gb_io_pkg;

	// plain vectors --------------------
	typedef logic [15:0] io_addr_t;  // CPU address
	typedef logic [7:0]  io_data_t;  // data byte

	// bit 0 vblank, 1 lcd, 2 timer, 3 serial, 4 joypad
	// lowest index wins
	typedef logic [4:0] irq_bits_t;

	typedef logic [3:0] joy_lines_t;  // P10..P13

	// CPU side of the register bus --------------------
	typedef struct packed {
		io_addr_t addr;
		io_data_t wdata;
		logic     wr;     // one-cycle write strobe
	} cpu_bus_t;

	// one-hot register block selects
	typedef struct packed {
		logic sel_joy;    // FF00
		logic sel_timer;  // FF04..FF07
		logic sel_if;     // FF0F
		logic sel_ie;     // FFFF
	} io_sel_t;

	// acknowledge cycle tracking
	typedef enum logic {
		IRQ_IDLE,
		IRQ_ACK
	} irq_state_t;

endpackage

// File: gb_io_defs.svh
// Game Boy I/O core constants
// register map, reset values, interrupt vectors and timer taps
`ifndef GB_IO_DEFS_SVH
`define GB_IO_DEFS_SVH

// register addresses --------------------
`define IO_ADDR_P1    16'hFF00  // joypad
`define IO_ADDR_DIV   16'hFF04  // divider, upper counter byte
`define IO_ADDR_TIMA  16'hFF05  // timer counter
`define IO_ADDR_TMA   16'hFF06  // timer modulo
`define IO_ADDR_TAC   16'hFF07  // timer control
`define IO_ADDR_IF    16'hFF0F  // interrupt flags
`define IO_ADDR_IE    16'hFFFF  // interrupt enable

// reset values --------------------
`define IF_RESET_VAL    5'h00
`define IE_RESET_VAL    8'h00
`define TIMA_RESET_VAL  8'h00
`define TMA_RESET_VAL   8'h00
`define TAC_RESET_VAL   3'h0
`define P54_RESET_VAL   2'b00

// interrupt vectors, base plus index times step
`define IRQ_VEC_BASE  8'h40
`define IRQ_VEC_STEP  8'h08

// system counter bit per TAC mode
`define TIMER_TAP_0  9  // 1024 cycles
`define TIMER_TAP_1  3  // 16 cycles
`define TIMER_TAP_2  5  // 64 cycles
`define TIMER_TAP_3  7  // 256 cycles

// nothing mapped here
`define OPEN_BUS_DATA  8'hFF

`endif
